/* tb.f */
adc_cfg_pkg.sv
adc_seq_pkg.sv
adc_edge_sync.sv
adc_chan_select.sv
adc_sequencer.sv
adc_sample_fifo.sv
adc_control_top.sv
tb_adc_model.sv
tb_adc_control.sv

/* run.sh */
#!/bin/sh
# build and run the adc controller testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_adc_control \
	-f tb.f --Mdir obj_dir -o tb_adc_sim \
	&& ./obj_dir/tb_adc_sim > sim.log 2>&1 \
	|| { echo "build or simulation error, see sim.log"; exit 1; }
cat sim.log
grep -q "tests failed" sim.log && { echo "simulation reported a failure"; exit 1; }
echo "simulation finished without failure"
exit 0

/* tb_adc_control.sv */
//##########################################################################
// testbench for the adc controller
// clock, reset, five tests over the modes and the fifo
// sample scoreboard, host reader, concurrent checks
// watchdog and summary
//##########################################################################
`timescale 1ns/1ps
module tb_adc_control;

	import adc_cfg_pkg::*;

	localparam int TB_NUM_CH = 8;
	localparam int TB_DEPTH = 16;
	localparam int CH_W = $clog2(TB_NUM_CH);
	localparam int NUM_TESTS = 5;
	// longest run is a full scan done three times
	localparam int MAX_CONV = TB_NUM_CH * 3;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * MAX_CONV * 12 + 2000;

	logic clk_32m;
	logic rstb;
	logic start;
	adc_mode_e mode;
	logic [TB_NUM_CH-1:0] ch_enable;
	logic [ROUND_W-1:0] round_num;
	logic adc_ckout;
	logic [SAMPLE_W-1:0] adc_dout;
	logic rd_en;
	logic [LEVEL_W-1:0] half_level;
	logic [LEVEL_W-1:0] full_level;
	logic adc_start;
	logic [TB_NUM_CH-1:0] adc_in_sel;
	logic [SAMPLE_W-1:0] sample;
	logic sample_valid;
	logic [SAMPLE_W-1:0] dout;
	logic valid;
	logic empty;
	logic full;
	logic [LEVEL_W-1:0] level;
	logic half_irq;
	logic full_irq;

	logic reading;
	logic single_done;
	logic half_exp;
	logic valid_exp;
	logic full_exp;
	int errors;
	int n_pass;
	int n_fail;
	int n_samples;
	int exp_ch;
	logic [SAMPLE_W-1:0] ref_fifo [256];
	logic [7:0] ref_wr;
	logic [7:0] ref_rd;
	logic [7:0] ref_count;
	logic [SAMPLE_W-1:0] exp_dout;

	adc_control_top #(
		.NUM_CH     (TB_NUM_CH),
		.FIFO_DEPTH (TB_DEPTH)
	) dut0 (
		.*
	);

	tb_adc_model #(
		.NUM_CH (TB_NUM_CH)
	) model0 (
		.*
	);

	initial
	begin
		clk_32m = 1'b0;
		forever #20 clk_32m = ~clk_32m;
	end

	// n-th enabled channel counting down from the top one
	function automatic int nth_enabled(input logic [TB_NUM_CH-1:0] en, input int n);
		int seen;
		seen = 0;
		for (int ch = TB_NUM_CH - 1; ch >= 0; ch--)
		begin
			if (en[ch])
			begin
				if (seen == n)
					return ch;
				seen++;
			end
		end
		return TB_NUM_CH - 1;
	endfunction

	always_comb
	begin
		if (mode == mode_continuous || ch_enable == '0)
			exp_ch = nth_enabled(ch_enable, 0);
		else
			exp_ch = nth_enabled(ch_enable, n_samples % $countones(ch_enable));
	end

	assign ref_count = ref_wr - ref_rd;
	assign full_exp = (ref_count == 8'(TB_DEPTH));

	// reads leave the scoreboard on the cycle they are accepted
	always @(posedge clk_32m or negedge rstb)
	begin
		if (!rstb)
		begin
			n_samples <= 0;
			single_done <= 1'b0;
			ref_wr <= '0;
			ref_rd <= '0;
			half_exp <= 1'b0;
			valid_exp <= 1'b0;
		end
		else
		begin
			if (!start)
			begin
				n_samples <= 0;
				single_done <= 1'b0;
			end
			else if (sample_valid)
			begin
				n_samples <= n_samples + 1;
				single_done <= (mode == mode_single);
			end
			if (sample_valid && ref_count < 8'(TB_DEPTH))
				ref_wr <= ref_wr + 1'b1;
			if (rd_en && ref_count != '0)
				ref_rd <= ref_rd + 1'b1;
			half_exp <= (ref_count >= half_level);
			valid_exp <= rd_en && (ref_count != '0);
		end
	end

	always @(posedge clk_32m)
	begin
		if (sample_valid && ref_count < 8'(TB_DEPTH))
			ref_fifo[ref_wr] <= sample;
		if (rd_en && ref_count != '0)
			exp_dout <= ref_fifo[ref_rd];
	end

	a_channel: assert property (@(posedge clk_32m) disable iff (!rstb)
		sample_valid |-> int'(sample[SAMPLE_W-1 -: CH_W]) == exp_ch)
	else
	begin
		$display("ERROR %0t sample channel got %0d expected %0d", $time,
			$sampled(sample[SAMPLE_W-1 -: CH_W]), $sampled(exp_ch));
		errors++;
	end

	a_single_idle: assert property (@(posedge clk_32m) disable iff (!rstb)
		single_done |-> !adc_start)
	else
	begin
		$display("ERROR %0t adc_start got 1 expected 0 after single sample", $time);
		errors++;
	end

	a_full_stall: assert property (@(posedge clk_32m) disable iff (!rstb)
		full_irq |-> !adc_start)
	else
	begin
		$display("ERROR %0t adc_start got 1 expected 0 while full_irq", $time);
		errors++;
	end

	a_level_cap: assert property (@(posedge clk_32m) disable iff (!rstb)
		level <= full_level)
	else
	begin
		$display("ERROR %0t level got %0d expected at most %0d", $time,
			$sampled(level), $sampled(full_level));
		errors++;
	end

	a_half_irq: assert property (@(posedge clk_32m) disable iff (!rstb)
		half_irq == half_exp)
	else
	begin
		$display("ERROR %0t half_irq got %b expected %b", $time,
			$sampled(half_irq), $sampled(half_exp));
		errors++;
	end

	a_full: assert property (@(posedge clk_32m) disable iff (!rstb)
		full == full_exp)
	else
	begin
		$display("ERROR %0t full got %b expected %b", $time,
			$sampled(full), $sampled(full_exp));
		errors++;
	end

	a_valid: assert property (@(posedge clk_32m) disable iff (!rstb)
		valid == valid_exp)
	else
	begin
		$display("ERROR %0t valid got %b expected %b", $time,
			$sampled(valid), $sampled(valid_exp));
		errors++;
	end

	a_dout: assert property (@(posedge clk_32m) disable iff (!rstb)
		valid |-> dout == exp_dout)
	else
	begin
		$display("ERROR %0t dout got %h expected %h", $time,
			$sampled(dout), $sampled(exp_dout));
		errors++;
	end

	task automatic check_value(input string name, input int got, input int exp);
		assert (got == exp)
		else
		begin
			$display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic begin_run(input adc_mode_e m, input int rounds);
		@(negedge clk_32m);
		mode = m;
		round_num = ROUND_W'(rounds);
		ch_enable = TB_NUM_CH'($urandom_range((1 << TB_NUM_CH) - 1, 1));
		@(negedge clk_32m);
		start = 1'b1;
	endtask

	task automatic stop_run();
		@(negedge clk_32m);
		start = 1'b0;
		reading = 1'b0;
		repeat (6) @(negedge clk_32m);
	endtask

	task automatic wait_samples(input int count);
		int limit;
		limit = count * 40 + 100;
		while (n_samples < count && limit > 0)
		begin
			@(negedge clk_32m);
			limit--;
		end
		if (n_samples < count)
		begin
			$display("timeout, only %0d of %0d samples arrived", n_samples, count);
			errors++;
		end
		// room for any extra sample to show up
		repeat (40) @(negedge clk_32m);
		check_value("sample count", n_samples, count);
	endtask

	task automatic drain_fifo();
		int limit;
		limit = 400;
		reading = 1'b1;
		while (!empty && limit > 0)
		begin
			@(negedge clk_32m);
			limit--;
		end
		// keep reading on the empty fifo for a while
		repeat (20) @(negedge clk_32m);
		reading = 1'b0;
		repeat (6) @(negedge clk_32m);
		check_value("empty", int'(empty), 1);
		check_value("scoreboard count", int'(ref_count), 0);
	endtask

	task automatic report_test(input int num, input string name, input int err_mark);
		if (errors == err_mark)
		begin
			n_pass++;
			$display("test %0d %s: pass", num, name);
		end
		else
		begin
			n_fail++;
			$display("test %0d %s: FAIL", num, name);
		end
	endtask

	initial
	begin : host_reader
		int gap;
		rd_en = 1'b0;
		forever
		begin
			@(negedge clk_32m);
			if (reading)
			begin
				rd_en = 1'b1;
				@(negedge clk_32m);
				rd_en = 1'b0;
				gap = $urandom_range(3, 0);
				repeat (gap) @(negedge clk_32m);
			end
		end
	end

	initial
	begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk_32m);
		$display("watchdog expired before the tests finished");
		$display("tests failed");
		$finish;
	end

	initial
	begin : main_seq
		int seed_val;
		int err_mark;
		int rounds;
		int limit;
		seed_val = $urandom(32'h3ab4);
		errors = 0;
		n_pass = 0;
		n_fail = 0;
		rstb = 1'b0;
		start = 1'b0;
		reading = 1'b0;
		mode = mode_single;
		ch_enable = '0;
		round_num = '0;
		full_level = LEVEL_W'($urandom_range(TB_DEPTH, 4));
		half_level = LEVEL_W'($urandom_range(int'(full_level), 1));
		repeat (5) @(negedge clk_32m);
		rstb = 1'b1;
		check_value("adc_start", int'(adc_start), 0);
		check_value("empty", int'(empty), 1);
		check_value("full_irq", int'(full_irq), 0);
		check_value("adc_in_sel", int'(adc_in_sel), 1 << (TB_NUM_CH - 1));

		err_mark = errors;
		begin_run(mode_single, 0);
		wait_samples(1);
		stop_run();
		drain_fifo();
		report_test(1, "single", err_mark);

		err_mark = errors;
		begin_run(mode_scan, 0);
		reading = 1'b1;
		wait_samples($countones(ch_enable));
		stop_run();
		drain_fifo();
		report_test(2, "scan", err_mark);

		err_mark = errors;
		rounds = $urandom_range(2, 1);
		begin_run(mode_scan_rounds, rounds);
		reading = 1'b1;
		wait_samples($countones(ch_enable) * (rounds + 1));
		stop_run();
		drain_fifo();
		report_test(3, "scan rounds", err_mark);

		// no reads here so the fifo fills up to full_level
		err_mark = errors;
		begin_run(mode_continuous, 0);
		limit = TB_DEPTH * 40;
		while (!full_irq && limit > 0)
		begin
			@(negedge clk_32m);
			limit--;
		end
		repeat (60) @(negedge clk_32m);
		check_value("level", int'(level), int'(full_level));
		check_value("sample count", n_samples, int'(full_level));
		stop_run();
		report_test(4, "continuous", err_mark);

		err_mark = errors;
		drain_fifo();
		report_test(5, "fifo reads", err_mark);

		$display("summary: %0d run, %0d passed, %0d failed, %0d errors",
			NUM_TESTS, n_pass, n_fail, errors);
		if (n_fail == 0 && errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* tb_adc_model.sv */
//##########################################################################
// converter model for the adc controller testbench
// answers adc_start with a falling adc_ckout after a random delay
// data holds the selected channel on top and a running count below
//##########################################################################
`timescale 1ns/1ps
module tb_adc_model #(
	parameter int NUM_CH = adc_cfg_pkg::NUM_CH
) (
	input  logic                             clk_32m,
	input  logic                             adc_start,
	input  logic [NUM_CH-1:0]                adc_in_sel,
	output logic                             adc_ckout,
	output logic [adc_cfg_pkg::SAMPLE_W-1:0] adc_dout
);

	import adc_cfg_pkg::*;

	localparam int CH_W = $clog2(NUM_CH);

	function automatic logic [CH_W-1:0] sel_index(input logic [NUM_CH-1:0] sel);
		logic [CH_W-1:0] idx;
		idx = '0;
		for (int i = 0; i < NUM_CH; i++)
		begin
			if (sel[i])
				idx = CH_W'(i);
		end
		return idx;
	endfunction

	initial
	begin : convert
		int delay;
		logic [SAMPLE_W-CH_W-1:0] count;
		adc_ckout = 1'b1;
		adc_dout = '0;
		count = '0;
		forever
		begin
			@(posedge adc_start);
			delay = $urandom_range(9, 4);
			repeat (delay) @(negedge clk_32m);
			// data stays put until the next conversion ends
			adc_dout = {sel_index(adc_in_sel), count};
			count = count + 1'b1;
			adc_ckout = 1'b0;
			wait (!adc_start);
			@(negedge clk_32m);
			adc_ckout = 1'b1;
		end
	end

endmodule

/* adc_control_top.sv */
//##########################################################################
// adc controller top level
// input synchronizer, sequencer with channel select, sample fifo
//##########################################################################
`timescale 1ns/1ps
module adc_control_top #(
	parameter int NUM_CH = adc_cfg_pkg::NUM_CH,
	parameter int FIFO_DEPTH = adc_cfg_pkg::FIFO_DEPTH
) (
	input  logic                             clk_32m,
	input  logic                             rstb,
	input  logic                             start,
	input  adc_cfg_pkg::adc_mode_e           mode,
	input  logic [NUM_CH-1:0]                ch_enable,
	input  logic [adc_cfg_pkg::ROUND_W-1:0]  round_num,
	input  logic                             adc_ckout,
	input  logic [adc_cfg_pkg::SAMPLE_W-1:0] adc_dout,
	input  logic                             rd_en,
	input  logic [adc_cfg_pkg::LEVEL_W-1:0]  half_level,
	input  logic [adc_cfg_pkg::LEVEL_W-1:0]  full_level,
	output logic                             adc_start,
	output logic [NUM_CH-1:0]                adc_in_sel,
	output logic [adc_cfg_pkg::SAMPLE_W-1:0] sample,
	output logic                             sample_valid,
	output logic [adc_cfg_pkg::SAMPLE_W-1:0] dout,
	output logic                             valid,
	output logic                             empty,
	output logic                             full,
	output logic [adc_cfg_pkg::LEVEL_W-1:0]  level,
	output logic                             half_irq,
	output logic                             full_irq
);

	logic start_sync;
	logic start_rise;
	logic ckout_fall;
	logic chan_load;
	logic chan_advance;
	logic at_first;

	adc_edge_sync u_edge_sync (
		.clk_32m    (clk_32m),
		.rstb       (rstb),
		.start      (start),
		.adc_ckout  (adc_ckout),
		.start_sync (start_sync),
		.start_rise (start_rise),
		.ckout_fall (ckout_fall)
	);

	adc_sequencer u_sequencer (
		.clk_32m      (clk_32m),
		.rstb         (rstb),
		.mode         (mode),
		.round_num    (round_num),
		.start_sync   (start_sync),
		.start_rise   (start_rise),
		.ckout_fall   (ckout_fall),
		.full_irq     (full_irq),
		.at_first     (at_first),
		.adc_dout     (adc_dout),
		.adc_start    (adc_start),
		.chan_load    (chan_load),
		.chan_advance (chan_advance),
		.sample       (sample),
		.sample_valid (sample_valid)
	);

	adc_chan_select #(
		.NUM_CH (NUM_CH)
	) u_chan_select (
		.clk_32m      (clk_32m),
		.rstb         (rstb),
		.ch_enable    (ch_enable),
		.chan_load    (chan_load),
		.chan_advance (chan_advance),
		.adc_in_sel   (adc_in_sel),
		.at_first     (at_first)
	);

	adc_sample_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_sample_fifo (
		.clk_32m    (clk_32m),
		.rstb       (rstb),
		.wr_en      (sample_valid),
		.din        (sample),
		.rd_en      (rd_en),
		.half_level (half_level),
		.full_level (full_level),
		.dout       (dout),
		.valid      (valid),
		.empty      (empty),
		.full       (full),
		.level      (level),
		.half_irq   (half_irq),
		.full_irq   (full_irq)
	);

endmodule

/* adc_sample_fifo.sv */
//##########################################################################
// synchronous sample fifo on a register array
// level count with half and full threshold interrupts
// read data and valid one cycle after rd_en
//##########################################################################
`timescale 1ns/1ps
module adc_sample_fifo #(
	parameter int FIFO_DEPTH = adc_cfg_pkg::FIFO_DEPTH
) (
	input  logic                             clk_32m,
	input  logic                             rstb,
	input  logic                             wr_en,
	input  logic [adc_cfg_pkg::SAMPLE_W-1:0] din,
	input  logic                             rd_en,
	input  logic [adc_cfg_pkg::LEVEL_W-1:0]  half_level,
	input  logic [adc_cfg_pkg::LEVEL_W-1:0]  full_level,
	output logic [adc_cfg_pkg::SAMPLE_W-1:0] dout,
	output logic                             valid,
	output logic                             empty,
	output logic                             full,
	output logic [adc_cfg_pkg::LEVEL_W-1:0]  level,
	output logic                             half_irq,
	output logic                             full_irq
);

	import adc_cfg_pkg::*;

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

	logic [SAMPLE_W-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic wr_ok;
	logic rd_ok;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(FIFO_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign empty = (level == '0);
	assign full = (level == LEVEL_W'(FIFO_DEPTH));
	assign wr_ok = wr_en && !full;
	assign rd_ok = rd_en && !empty;

	always_ff @(posedge clk_32m or negedge rstb)
	begin
		if (!rstb)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
			valid <= 1'b0;
			half_irq <= 1'b0;
			full_irq <= 1'b0;
		end
		else
		begin
			if (wr_ok)
				wr_ptr <= ptr_inc(wr_ptr);
			if (rd_ok)
				rd_ptr <= ptr_inc(rd_ptr);
			// simultaneous read and write leave the level unchanged
			if (wr_ok && !rd_ok)
				level <= level + 1'b1;
			else if (rd_ok && !wr_ok)
				level <= level - 1'b1;
			valid <= rd_ok;
			half_irq <= (level >= half_level);
			full_irq <= (level >= full_level);
		end
	end

	always_ff @(posedge clk_32m)
	begin
		if (wr_ok)
			mem[wr_ptr] <= din;
		if (rd_ok)
			dout <= mem[rd_ptr];
	end

	a_level_bound: assert property (
		@(posedge clk_32m) disable iff (!rstb) level <= LEVEL_W'(FIFO_DEPTH)
	) else $error("fifo level above depth");

endmodule

/* adc_sequencer.sv */
//##########################################################################
// conversion sequencer
// state machine for single, continuous, scan and counted scan modes
// round counter for counted scans
// last-sample register with its strobe
//##########################################################################
`timescale 1ns/1ps
module adc_sequencer (
	input  logic                             clk_32m,
	input  logic                             rstb,
	input  adc_cfg_pkg::adc_mode_e           mode,
	input  logic [adc_cfg_pkg::ROUND_W-1:0]  round_num,
	input  logic                             start_sync,
	input  logic                             start_rise,
	input  logic                             ckout_fall,
	input  logic                             full_irq,
	input  logic                             at_first,
	input  logic [adc_cfg_pkg::SAMPLE_W-1:0] adc_dout,
	output logic                             adc_start,
	output logic                             chan_load,
	output logic                             chan_advance,
	output logic [adc_cfg_pkg::SAMPLE_W-1:0] sample,
	output logic                             sample_valid
);

	import adc_cfg_pkg::*;
	import adc_seq_pkg::*;

	seq_state_e state;
	seq_state_e state_next;
	logic [ROUND_W-1:0] round_cnt;
	logic capture;
	logic sample_settle;
	logic fifo_busy;

	assign capture = (state == st_convert) && start_sync && ckout_fall;

	// full_irq trails a write by two cycles, hold off until it has caught up
	assign fifo_busy = sample_valid | sample_settle;

	always_comb
	begin
		state_next = state;
		case (state)
			st_idle:
				if (start_rise && !full_irq)
					state_next = st_convert;
			st_convert:
				if (ckout_fall)
				begin
					case (mode)
						mode_single:     state_next = st_idle;
						mode_continuous: state_next = st_select_wait;
						default:         state_next = st_advance;
					endcase
				end
			st_select_wait:
				if (!fifo_busy && !full_irq)
					state_next = st_convert;
			st_advance, st_advance_wait:
				if (!fifo_busy && !full_irq)
					state_next = st_round;
				else
					state_next = st_advance_wait;
			st_round:
				// back on the first channel means a round is done
				if (!at_first)
					state_next = st_convert;
				else if (mode == mode_scan_rounds && round_cnt < round_num)
					state_next = st_convert;
				else
					state_next = st_idle;
			default:
				state_next = st_idle;
		endcase
		// dropping start aborts from anywhere
		if (!start_sync)
			state_next = st_idle;
	end

	assign chan_load = (state == st_idle) && (state_next == st_convert);
	assign chan_advance = (state == st_advance);

	always_ff @(posedge clk_32m or negedge rstb)
	begin
		if (!rstb)
		begin
			state <= st_idle;
			adc_start <= 1'b0;
			sample_valid <= 1'b0;
			sample_settle <= 1'b0;
		end
		else
		begin
			state <= state_next;
			adc_start <= (state_next == st_convert);
			sample_valid <= capture;
			sample_settle <= sample_valid;
		end
	end

	always_ff @(posedge clk_32m or negedge rstb)
	begin
		if (!rstb)
			round_cnt <= '0;
		else if (state == st_idle)
			round_cnt <= '0;
		else if (state == st_round && at_first && state_next == st_convert)
			round_cnt <= round_cnt + 1'b1;
	end

	always_ff @(posedge clk_32m)
	begin
		if (capture)
			sample <= adc_dout;
	end

	a_start_only_in_convert: assert property (
		@(posedge clk_32m) disable iff (!rstb) (state != st_convert) |-> !adc_start
	) else $error("adc_start high outside st_convert");

endmodule

/* adc_chan_select.sv */
//##########################################################################
// one-hot channel select register
// load picks the highest enabled channel and remembers it as first channel
// advance steps to the next lower enabled channel, wrapping at the bottom
//##########################################################################
`timescale 1ns/1ps
module adc_chan_select #(
	parameter int NUM_CH = adc_cfg_pkg::NUM_CH
) (
	input  logic              clk_32m,
	input  logic              rstb,
	input  logic [NUM_CH-1:0] ch_enable,
	input  logic              chan_load,
	input  logic              chan_advance,
	output logic [NUM_CH-1:0] adc_in_sel,
	output logic              at_first
);

	localparam logic [NUM_CH-1:0] TOP_CH = {1'b1, {(NUM_CH-1){1'b0}}};

	logic [NUM_CH-1:0] first_sel;
	logic [NUM_CH-1:0] load_sel;
	logic [NUM_CH-1:0] next_sel;

	// highest enabled channel wins, top channel if none enabled
	always_comb
	begin
		load_sel = TOP_CH;
		for (int i = 0; i < NUM_CH; i++)
		begin
			if (ch_enable[i])
			begin
				load_sel = '0;
				load_sel[i] = 1'b1;
			end
		end
	end

	always_comb
	begin : advance_pick
		int cur;
		int idx;
		logic found;
		cur = 0;
		for (int i = 0; i < NUM_CH; i++)
		begin
			if (adc_in_sel[i])
				cur = i;
		end
		// walk downward from the current channel, wrap to the top
		next_sel = adc_in_sel;
		found = 1'b0;
		for (int step = 1; step < NUM_CH; step++)
		begin
			idx = (cur + NUM_CH - step) % NUM_CH;
			if (!found && ch_enable[idx])
			begin
				next_sel = '0;
				next_sel[idx] = 1'b1;
				found = 1'b1;
			end
		end
	end

	always_ff @(posedge clk_32m or negedge rstb)
	begin
		if (!rstb)
		begin
			adc_in_sel <= TOP_CH;
			first_sel <= TOP_CH;
		end
		else if (chan_load)
		begin
			adc_in_sel <= load_sel;
			first_sel <= load_sel;
		end
		else if (chan_advance)
			adc_in_sel <= next_sel;
	end

	assign at_first = (adc_in_sel == first_sel);

	a_sel_onehot: assert property (
		@(posedge clk_32m) disable iff (!rstb) $onehot(adc_in_sel)
	) else $error("adc_in_sel not one-hot");

endmodule

/* adc_edge_sync.sv */
//##########################################################################
// input synchronizer for the start request and the converter done clock
// rising edge pulse on start, falling edge pulse on adc_ckout
//##########################################################################
`timescale 1ns/1ps
module adc_edge_sync (
	input  logic clk_32m,
	input  logic rstb,
	input  logic start,
	input  logic adc_ckout,
	output logic start_sync,
	output logic start_rise,
	output logic ckout_fall
);

	// bit 0 carries start, bit 1 carries adc_ckout
	logic [1:0] sync_r0;
	logic [1:0] sync_r1;
	logic [1:0] sync_r2;

	always_ff @(posedge clk_32m or negedge rstb)
	begin
		if (!rstb)
		begin
			sync_r0 <= '0;
			sync_r1 <= '0;
			sync_r2 <= '0;
			start_rise <= 1'b0;
			ckout_fall <= 1'b0;
		end
		else
		begin
			sync_r0 <= {adc_ckout, start};
			sync_r1 <= sync_r0;
			sync_r2 <= sync_r1;
			start_rise <= sync_r1[0] & ~sync_r2[0];
			ckout_fall <= ~sync_r1[1] & sync_r2[1];
		end
	end

	assign start_sync = sync_r1[0];

	a_start_rise_single: assert property (
		@(posedge clk_32m) disable iff (!rstb) start_rise |=> !start_rise
	) else $error("start_rise longer than one cycle");

	a_ckout_fall_single: assert property (
		@(posedge clk_32m) disable iff (!rstb) ckout_fall |=> !ckout_fall
	) else $error("ckout_fall longer than one cycle");

endmodule

/* adc_seq_pkg.sv */
//##########################################################################
// conversion sequencer state encoding
//##########################################################################
package adc_seq_pkg;

	localparam int SEQ_STATE_W = 3;

	typedef enum logic [SEQ_STATE_W-1:0]
	{
		st_idle         = 3'd0,
		st_convert      = 3'd1,
		st_select_wait  = 3'd2,
		st_advance      = 3'd3,
		st_advance_wait = 3'd4,
		st_round        = 3'd5
	} seq_state_e;

endpackage

/* adc_cfg_pkg.sv */
//##########################################################################
// configuration constants for the adc controller
// channel count and converter sample width
// sample fifo depth and level width
// round counter width and the conversion mode opcodes
//##########################################################################
package adc_cfg_pkg;

	// converter side
	localparam int NUM_CH = 8;
	localparam int SAMPLE_W = 10;

	// sample fifo, level must hold FIFO_DEPTH
	localparam int FIFO_DEPTH = 16;
	localparam int LEVEL_W = 5;

	localparam int ROUND_W = 16;

	typedef enum logic [1:0]
	{
		mode_single      = 2'd0,
		mode_continuous  = 2'd1,
		mode_scan        = 2'd2,
		mode_scan_rounds = 2'd3
	} adc_mode_e;

endpackage
